/* project.f */
source/worksheet_pkg.sv
source/problem_store.sv
source/column_decoder.sv
source/problem_reducer.sv
source/worksheet_sequencer.sv
source/worksheet_solver.sv
dv/worksheet_solver_chk.sv
dv/tb_worksheet_solver.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing --assert
TOP       := tb_worksheet_solver
FILELIST  := project.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qx "TB PASSED" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/tb_worksheet_solver.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_worksheet_solver
    import worksheet_pkg::*;
();

    localparam int num_problems  = 8;
    localparam int idx_w         = $clog2(num_problems);
    localparam int adr_w         = idx_w + field_w;
    localparam int bus_cycles    = 4;    // handshake plus release
    localparam int transfers     = 179;  // bus transfers over all tests
    localparam int run_cycles    = num_problems + 8;
    localparam int timeout_limit = 20 * (bus_cycles * transfers + 4 * run_cycles + 12);

    logic                clk;
    logic                rst;
    logic                start;
    logic                finished;
    logic [result_w-1:0] result;
    logic                wb_cyc;
    logic                wb_stb;
    logic                wb_we;
    logic [adr_w-1:0]    wb_adr;
    logic [row_w-1:0]    wb_dat_w;
    logic [row_w-1:0]    wb_dat_r;
    logic                wb_ack;

    logic [row_w-1:0] shadow_rows [num_problems][rows_per_problem];
    logic             shadow_op   [num_problems];
    logic [31:0]      lfsr_state    = 32'h8c8f;
    int               cycle_count   = 0;
    bit               verdict_given = 1'b0;

    worksheet_solver #(.num_problems(num_problems)) uut (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .finished (finished),
        .result   (result),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    always #10 clk = ~clk;

    initial begin
        while (cycle_count < timeout_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        fail_run($sformatf("timeout after %0d cycles, tests did not complete", cycle_count));
    end

    task automatic fail_run(input string why);
        verdict_given = 1'b1;
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_mismatch(input string name, input logic [result_w-1:0] expected,
                                   input logic [result_w-1:0] actual);
        fail_run($sformatf("Mismatch %s: expected %h, actual %h", name, expected, actual));
    endtask

    task automatic check_row(input string name, input row_word_u expected,
                             input row_word_u actual);
        if (actual !== expected) begin
            report_mismatch(name, result_w'(expected.raw), result_w'(actual.raw));
        end
    endtask

    task automatic check_result(input string name, input logic [result_w-1:0] expected,
                                input logic [result_w-1:0] actual);
        if (actual !== expected) report_mismatch(name, expected, actual);
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) report_mismatch(name, result_w'(expected), result_w'(actual));
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual !== expected) report_mismatch(name, result_w'(expected), result_w'(actual));
    endtask

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits = {bits[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return bits;
    endfunction

    function automatic row_word_u random_row();
        row_word_u w;
        for (int c = 0; c < rows_per_problem; c++) begin
            w.digits[c] = digit_w'(take_bits(digit_w) % 10);
        end
        return w;
    endfunction

    function automatic logic [adr_w-1:0] bus_address(input int p, input logic [field_w-1:0] f);
        return {idx_w'(p), f};
    endfunction

    function automatic logic [row_w-1:0] fill_pattern(input int p, input int r);
        return (row_w'(bus_address(p, field_w'(r))) * 16'h0b3d) ^ 16'h5a5a;
    endfunction

    // column value from the blank row rules
    function automatic logic [row_w-1:0] expected_column(input int p, input int c);
        logic [digit_w-1:0] d [rows_per_problem];
        logic [row_w-1:0]   v;
        for (int r = 0; r < rows_per_problem; r++) begin
            d[r] = shadow_rows[p][r][c*digit_w +: digit_w];
        end
        if (d[1] == '0 && d[2] == '0 && d[3] == '0) begin
            v = row_w'(d[0]);
        end else if (d[2] == '0 && d[3] == '0) begin
            v = row_w'(10 * d[0] + d[1]);
        end else if (d[3] == '0) begin
            v = row_w'(100 * d[0] + 10 * d[1] + d[2]);
        end else begin
            v = row_w'(1000 * d[0] + 100 * d[1] + 10 * d[2] + d[3]);
        end
        if (shadow_op[p] == op_mul && v == '0) v = row_w'(1);
        return v;
    endfunction

    function automatic logic [result_w-1:0] expected_sum();
        logic [result_w-1:0] sum;
        logic [result_w-1:0] acc;
        sum = '0;
        for (int p = 0; p < num_problems; p++) begin
            acc = (shadow_op[p] == op_add) ? result_w'(0) : result_w'(1);
            for (int c = 0; c < rows_per_problem; c++) begin
                if (shadow_op[p] == op_add) acc = acc + result_w'(expected_column(p, c));
                else acc = acc * result_w'(expected_column(p, c));
            end
            sum = sum + acc;
        end
        return sum;
    endfunction

    task automatic wb_transfer(input logic we, input logic [adr_w-1:0] adr,
                               input logic [row_w-1:0] wdata, output logic [row_w-1:0] rdata);
        int waited;
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        @(negedge clk);
        waited = 1;
        while (!wb_ack) begin
            @(negedge clk);
            waited++;
        end
        check_count("wb_ack latency", 1, waited);
        rdata = wb_dat_r;
        @(negedge clk);  // ack taken on the edge before this
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input logic [adr_w-1:0] adr, input logic [row_w-1:0] data);
        logic [row_w-1:0] ignored;
        wb_transfer(1'b1, adr, data, ignored);
    endtask

    task automatic wb_read(input logic [adr_w-1:0] adr, output logic [row_w-1:0] data);
        wb_transfer(1'b0, adr, '0, data);
    endtask

    task automatic write_row(input int p, input int r, input logic [row_w-1:0] value);
        shadow_rows[p][r] = value;
        wb_write(bus_address(p, field_w'(r)), value);
    endtask

    task automatic write_op(input int p, input logic o);
        shadow_op[p] = o;
        wb_write(bus_address(p, field_op), row_w'(o));
    endtask

    task automatic fill_zero_worksheet();
        for (int p = 0; p < num_problems; p++) begin
            for (int r = 0; r < rows_per_problem; r++) write_row(p, r, '0);
            write_op(p, op_mul);
        end
    endtask

    task automatic run_and_check(input logic [result_w-1:0] expected);
        int latency;
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        check_flag("finished", 1'b0, finished);  // cleared by the accepted start
        latency = 0;
        while (!finished) begin
            @(negedge clk);
            latency++;
        end
        check_count("finish latency", num_problems + 4, latency);
        check_result("result", expected, result);
    endtask

    task automatic test_bus_readback();
        logic [row_w-1:0] data;
        row_word_u        want;
        row_word_u        got;
        for (int p = 0; p < num_problems; p++) begin
            for (int r = 0; r < rows_per_problem; r++) write_row(p, r, fill_pattern(p, r));
            write_op(p, ^idx_w'(p));
        end
        wb_write(bus_address(2, 3'd5), 16'hffff);  // unmapped field
        for (int p = 0; p < num_problems; p++) begin
            for (int r = 0; r < rows_per_problem; r++) begin
                wb_read(bus_address(p, field_w'(r)), data);
                want.raw = shadow_rows[p][r];
                got.raw  = data;
                check_row("wb_dat_r row", want, got);
            end
            wb_read(bus_address(p, field_op), data);
            want.raw = row_w'(shadow_op[p]);
            got.raw  = data;
            check_row("wb_dat_r op", want, got);
        end
        for (int f = 5; f < 8; f++) begin
            wb_read(bus_address(2, field_w'(f)), data);
            want.raw = '0;
            got.raw  = data;
            check_row("wb_dat_r unmapped", want, got);
        end
    endtask

    task automatic test_add_blanks();
        fill_zero_worksheet();
        write_row(0, 0, 16'h4321);
        write_row(0, 1, 16'h7650);
        write_row(0, 2, 16'h9800);
        write_row(0, 3, 16'h2000);
        write_op(0, op_add);
        run_and_check(64'd5193);  // 1 + 25 + 368 + 4792 plus seven empty products of 1
    endtask

    task automatic test_mul_zero_column();
        write_row(0, 0, 16'h1203);
        write_row(0, 1, 16'h2100);
        write_row(0, 2, 16'h0000);
        write_row(0, 3, 16'h0000);
        write_op(0, op_mul);
        run_and_check(64'd763);  // 3 * 1 * 21 * 12 plus 7
    endtask

    task automatic test_random_worksheet();
        row_word_u w;
        for (int p = 0; p < num_problems; p++) begin
            for (int r = 0; r < rows_per_problem; r++) begin
                w = random_row();
                write_row(p, r, w.raw);
            end
            write_op(p, 1'(take_bits(1)));
        end
        run_and_check(expected_sum());
    endtask

    task automatic test_rerun();
        logic [result_w-1:0] prev_sum;
        row_word_u           w;
        prev_sum = expected_sum();
        check_flag("finished", 1'b1, finished);
        for (int r = 0; r < rows_per_problem; r++) begin
            w = random_row();
            write_row(3, r, w.raw);
        end
        write_op(3, ~shadow_op[3]);
        check_result("result held", prev_sum, result);
        run_and_check(expected_sum());
    endtask

    initial begin
        clk      = 1'b0;
        rst      = 1'b1;
        start    = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_flag("finished", 1'b0, finished);
        check_flag("wb_ack", 1'b0, wb_ack);
        check_result("result", '0, result);
        test_bus_readback();
        test_add_blanks();
        test_mul_zero_column();
        test_random_worksheet();
        test_rerun();
        verdict_given = 1'b1;
        $display("TB PASSED");
        $finish;
    end

    final begin
        if (!verdict_given) begin
            $display("simulation stopped before the tests completed");
            $display("TB FAILED");
        end
    end

endmodule

`default_nettype wire

/* dv/worksheet_solver_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module worksheet_solver_chk #(
    parameter int num_problems = 1000
) (
    input wire logic clk,
    input wire logic rst,
    input wire logic start,
    input wire logic finished,
    input wire logic wb_cyc,
    input wire logic wb_stb,
    input wire logic wb_ack,
    input wire logic issue_valid,
    input wire logic answer_valid
);

    logic ran_once;
    logic accept;

    assign accept = start && (!ran_once || finished);  // idle or done

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ran_once <= 1'b0;
        end else if (accept) begin
            ran_once <= 1'b1;
        end
    end

    ack_needs_request: assert property (@(posedge clk) disable iff (rst)
        wb_ack |-> wb_cyc && wb_stb)
        else $error("wb_ack high without an active cyc and stb");

    ack_single_cycle: assert property (@(posedge clk) disable iff (rst)
        wb_ack |=> !wb_ack)
        else $error("wb_ack high for two cycles in a row");

    finished_while_idle: assert property (@(posedge clk) disable iff (rst)
        (issue_valid || answer_valid) |-> !finished)
        else $error("finished high while problems are still in flight");

    // set on edge num_problems + 4 after accept and sampled high one edge later
    finish_latency: assert property (@(posedge clk) disable iff (rst)
        $rose(finished) |-> $past(accept, num_problems + 5))
        else $error("finished did not rise num_problems + 4 cycles after start");

endmodule

bind worksheet_solver worksheet_solver_chk #(.num_problems(num_problems)) u_chk (
    .clk          (clk),
    .rst          (rst),
    .start        (start),
    .finished     (finished),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_ack       (wb_ack),
    .issue_valid  (issue_valid),
    .answer_valid (answer_valid)
);

`default_nettype wire

/* source/worksheet_solver.sv */
`timescale 1ns/1ps
`default_nettype none

module worksheet_solver
    import worksheet_pkg::*;
#(
    parameter int num_problems = 1000,
    localparam int idx_w = $clog2(num_problems)
) (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire logic                     start,
    output logic                          finished,
    output logic      [result_w-1:0]      result,
    input  wire logic                     wb_cyc,
    input  wire logic                     wb_stb,
    input  wire logic                     wb_we,
    input  wire logic [idx_w+field_w-1:0] wb_adr,
    input  wire logic [row_w-1:0]         wb_dat_w,
    output logic      [row_w-1:0]         wb_dat_r,
    output logic                          wb_ack
);

    logic [idx_w-1:0]    issue_index;
    logic                issue_valid;
    row_word_u           rows [rows_per_problem];
    logic                op;
    logic [row_w-1:0]    col_values [rows_per_problem];
    logic [result_w-1:0] answer;
    logic                answer_valid;

    problem_store #(.num_problems(num_problems)) u_store (
        .clk         (clk),
        .rst         (rst),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack),
        .issue_index (issue_index),
        .rows        (rows),
        .op          (op)
    );

    column_decoder u_decoder (
        .rows       (rows),
        .op         (op),
        .col_values (col_values)
    );

    problem_reducer u_reducer (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (issue_valid),
        .op           (op),
        .col_values   (col_values),
        .answer       (answer),
        .answer_valid (answer_valid)
    );

    worksheet_sequencer #(.num_problems(num_problems)) u_sequencer (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .answer       (answer),
        .answer_valid (answer_valid),
        .issue_index  (issue_index),
        .issue_valid  (issue_valid),
        .finished     (finished),
        .result       (result)
    );

endmodule

`default_nettype wire

/* source/worksheet_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module worksheet_sequencer
    import worksheet_pkg::*;
#(
    parameter int num_problems = 1000,
    localparam int idx_w = $clog2(num_problems)
) (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                start,
    input  wire logic [result_w-1:0] answer,
    input  wire logic                answer_valid,
    output logic      [idx_w-1:0]    issue_index,
    output logic                     issue_valid,
    output logic                     finished,
    output logic      [result_w-1:0] result
);

    localparam int cnt_w = $clog2(num_problems + 1);

    localparam logic [1:0] st_idle  = 2'd0;
    localparam logic [1:0] st_issue = 2'd1;
    localparam logic [1:0] st_drain = 2'd2;
    localparam logic [1:0] st_done  = 2'd3;

    logic [1:0]       state;
    logic [cnt_w-1:0] retired;
    logic             accept;
    logic             last_issue;

    assign accept      = start && (state == st_idle || state == st_done);
    assign last_issue  = issue_index == idx_w'(num_problems - 1);
    assign issue_valid = state == st_issue;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= st_idle;
            issue_index <= '0;
            retired     <= '0;
            finished    <= 1'b0;
            result      <= '0;
        end else begin
            case (state)
                st_idle, st_done: begin
                    if (accept) begin
                        state       <= st_issue;
                        issue_index <= '0;
                        finished    <= 1'b0;
                    end
                end
                st_issue: begin
                    if (last_issue) begin
                        state <= st_drain;
                    end else begin
                        issue_index <= issue_index + 1'b1;  // one problem per cycle
                    end
                end
                st_drain: begin
                    if (retired == cnt_w'(num_problems)) begin
                        state    <= st_done;
                        finished <= 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase

            // running sum doubles as the result
            if (accept) begin
                result  <= '0;
                retired <= '0;
            end else if (answer_valid) begin
                result  <= result + answer;
                retired <= retired + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* source/problem_reducer.sv */
`timescale 1ns/1ps
`default_nettype none

module problem_reducer
    import worksheet_pkg::*;
(
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                in_valid,
    input  wire logic                op,
    input  wire logic [row_w-1:0]    col_values [rows_per_problem],
    output logic      [result_w-1:0] answer,
    output logic                     answer_valid
);

    logic                s1_valid;
    logic                s1_op;
    logic [row_w-1:0]    s1_val [rows_per_problem];
    logic                s2_valid;
    logic                s2_op;
    logic [result_w-1:0] s2_lo;
    logic [result_w-1:0] s2_hi;

    function automatic logic [result_w-1:0] combine(
        input logic                op_bit,
        input logic [result_w-1:0] a,
        input logic [result_w-1:0] b
    );
        return (op_bit == op_add) ? a + b : a * b;
    endfunction

    // valid bits
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1_valid     <= 1'b0;
            s2_valid     <= 1'b0;
            answer_valid <= 1'b0;
        end else begin
            s1_valid     <= in_valid;
            s2_valid     <= s1_valid;
            answer_valid <= s2_valid;
        end
    end

    // op travels with its own problem
    always_ff @(posedge clk) begin
        s1_op  <= op;
        s1_val <= col_values;
        s2_op  <= s1_op;
        s2_lo  <= combine(s1_op, result_w'(s1_val[0]), result_w'(s1_val[1]));
        s2_hi  <= combine(s1_op, result_w'(s1_val[2]), result_w'(s1_val[3]));
        answer <= combine(s2_op, s2_lo, s2_hi);
    end

endmodule

`default_nettype wire

/* source/column_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module column_decoder
    import worksheet_pkg::*;
(
    input  wire row_word_u      rows       [rows_per_problem],
    input  wire logic           op,
    output logic    [row_w-1:0] col_values [rows_per_problem]
);

    // column c reads digit c of each row with row 0 most significant
    for (genvar c = 0; c < rows_per_problem; c++) begin : g_col
        logic [row_w-1:0] value;

        always_comb begin
            logic tail_nz;
            value = row_w'(rows[0].digits[c]);
            for (int r = 1; r < rows_per_problem; r++) begin
                tail_nz = 1'b0;
                for (int k = r; k < rows_per_problem; k++) begin
                    tail_nz = tail_nz | (rows[k].digits[c] != '0);
                end
                // trailing blank rows contribute no digit
                if (tail_nz) begin
                    value = value * row_w'(10) + row_w'(rows[r].digits[c]);
                end
            end
        end

        // an empty column counts as one in a product
        assign col_values[c] = (op == op_mul && value == '0) ? row_w'(1) : value;
    end

endmodule

`default_nettype wire

/* source/problem_store.sv */
`timescale 1ns/1ps
`default_nettype none

module problem_store
    import worksheet_pkg::*;
#(
    parameter int num_problems = 1000,
    localparam int idx_w = $clog2(num_problems)
) (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire logic                     wb_cyc,
    input  wire logic                     wb_stb,
    input  wire logic                     wb_we,
    input  wire logic [idx_w+field_w-1:0] wb_adr,
    input  wire logic [row_w-1:0]         wb_dat_w,
    output logic      [row_w-1:0]         wb_dat_r,
    output logic                          wb_ack,
    input  wire logic [idx_w-1:0]         issue_index,
    output row_word_u                     rows [rows_per_problem],
    output logic                          op
);

    localparam int row_sel_w = $clog2(rows_per_problem);
    localparam logic [idx_w:0] index_limit = (idx_w + 1)'(num_problems);

    logic [row_w-1:0] row_mem [rows_per_problem][num_problems];
    logic             op_mem  [num_problems];

    logic [idx_w-1:0]     bus_index;
    logic [field_w-1:0]   field;
    logic [row_sel_w-1:0] row_sel;
    logic                 index_ok;
    logic                 bus_req;
    logic [row_w-1:0]     rd_data;

    assign bus_index = wb_adr[idx_w+field_w-1:field_w];
    assign field     = wb_adr[field_w-1:0];
    assign row_sel   = field[row_sel_w-1:0];
    assign index_ok  = {1'b0, bus_index} < index_limit;
    assign bus_req   = wb_cyc && wb_stb && !wb_ack;  // first cycle of a transfer

    always_comb begin
        rd_data = '0;  // unknown fields read zero
        if (index_ok) begin
            if (field <= field_row3) begin
                rd_data = row_mem[row_sel][bus_index];
            end else if (field == field_op) begin
                rd_data = row_w'(op_mem[bus_index]);
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= bus_req;  // single cycle ack
        end
    end

    always_ff @(posedge clk) begin
        if (bus_req) begin
            wb_dat_r <= rd_data;
            if (wb_we && index_ok) begin
                if (field <= field_row3) begin
                    row_mem[row_sel][bus_index] <= wb_dat_w;
                end else if (field == field_op) begin
                    op_mem[bus_index] <= wb_dat_w[0];
                end
            end
        end
    end

    // asynchronous read for the engine
    for (genvar r = 0; r < rows_per_problem; r++) begin : g_rows
        assign rows[r].raw = row_mem[r][issue_index];
    end
    assign op = op_mem[issue_index];

endmodule

`default_nettype wire

/* source/worksheet_pkg.sv */
`default_nettype none

package worksheet_pkg;

    localparam int digit_w          = 4;
    localparam int rows_per_problem = 4;   // also the column count
    localparam int row_w            = 16;
    localparam int result_w         = 64;
    localparam int field_w          = 3;

    // low address field of a bus word address
    localparam logic [field_w-1:0] field_row0 = 3'd0;
    localparam logic [field_w-1:0] field_row1 = 3'd1;
    localparam logic [field_w-1:0] field_row2 = 3'd2;
    localparam logic [field_w-1:0] field_row3 = 3'd3;
    localparam logic [field_w-1:0] field_op   = 3'd4;

    localparam logic op_mul = 1'b0;
    localparam logic op_add = 1'b1;

    // one row as raw bus word or four bcd digits
    typedef union packed {
        logic [row_w-1:0]                          raw;
        logic [rows_per_problem-1:0][digit_w-1:0] digits;  // digit 0 is the low nibble
    } row_word_u;

endpackage

`default_nettype wire
